//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:2] waddr_t;   // word address, byte offset dropped
   typedef logic [3:0]  strobe_t;
   typedef logic [4:0]  reg_idx_t;

   // major opcodes of the supported subset
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD = 3'b000;   // add, sub, addi
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_LW  = 3'b010;
   localparam logic [2:0] F3_LBU = 3'b100;
   localparam logic [2:0] F3_SB  = 3'b000;
   localparam logic [2:0] F3_SW  = 3'b010;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;
   localparam logic [6:0] F7_SUB = 7'b0100000;

   typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

   // r-type view of an instruction word
   typedef struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } instr_t;

endpackage

//--- rtl/core_pipe_pkg.sv
package core_pipe_pkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B   // lui
   } alu_op_e;

   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

   typedef enum logic [2:0] {MEM_NONE, MEM_LW, MEM_LBU, MEM_SW, MEM_SB} mem_op_e;

   typedef struct packed {
      logic              valid;
      rv_isa_pkg::word_t pc;
      rv_isa_pkg::word_t instr;
   } if_id_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::word_t    rs1_val;
      rv_isa_pkg::word_t    rs2_val;
      rv_isa_pkg::reg_idx_t rs1_idx;
      rv_isa_pkg::reg_idx_t rs2_idx;
      rv_isa_pkg::word_t    imm;
      alu_op_e              alu_op;
      logic                 op1_pc;    // op1 is pc, else rs1
      logic                 op2_imm;   // op2 is imm, else rs2
      logic                 is_branch;
      logic                 branch_ne;
      logic                 is_jal;
      mem_op_e              mem_op;
      wb_sel_e              wb_sel;
      rv_isa_pkg::reg_idx_t rd;
      logic                 reg_we;
   } id_ex_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::word_t    alu;
      rv_isa_pkg::word_t    store_data;
      mem_op_e              mem_op;
      wb_sel_e              wb_sel;
      rv_isa_pkg::reg_idx_t rd;
      logic                 reg_we;
   } ex_mem_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::word_t    pc;
      rv_isa_pkg::word_t    alu;
      rv_isa_pkg::word_t    load;
      wb_sel_e              wb_sel;
      rv_isa_pkg::reg_idx_t rd;
      logic                 reg_we;
   } mem_wb_t;

   typedef struct packed {
      logic                 we;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::word_t    data;
   } wb_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
   parameter rv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  freeze_i,
   input  logic                  stall_i,
   input  logic                  redirect_valid_i,
   input  rv_isa_pkg::word_t     redirect_pc_i,
   input  logic                  cache_blocking_n_i,
   input  rv_isa_pkg::word_t     cache_data_i,
   output rv_isa_pkg::waddr_t    cache_address_o,
   output core_pipe_pkg::if_id_t if_id_o
);

   rv_isa_pkg::word_t     pc_q;
   core_pipe_pkg::if_id_t if_id_q;

   assign cache_address_o = pc_q[31:2];
   assign if_id_o         = if_id_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q    <= RESET_PC;
         if_id_q <= '0;
      end else if (!freeze_i) begin
         if (redirect_valid_i) begin
            pc_q          <= redirect_pc_i;
            if_id_q.valid <= 1'b0;   // word in flight is on the wrong path
         end else if (!stall_i) begin
            if (cache_blocking_n_i) begin
               pc_q          <= pc_q + 32'd4;
               if_id_q.valid <= 1'b1;
               if_id_q.pc    <= pc_q;
               if_id_q.instr <= cache_data_i;
            end else begin
               if_id_q.valid <= 1'b0;   // icache busy, send a bubble
            end
         end
         // load-use stall keeps pc and IF/ID as they are
      end
   end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  freeze_i,
   input  logic                  flush_i,
   input  core_pipe_pkg::if_id_t if_id_i,
   input  core_pipe_pkg::wb_t    wb_i,
   output logic                  load_hazard_o,
   output core_pipe_pkg::id_ex_t id_ex_o
);

   rv_isa_pkg::instr_t    ins;
   rv_isa_pkg::word_t     ir;
   rv_isa_pkg::imm_kind_e imm_kind;
   rv_isa_pkg::word_t     regs [1:31];
   core_pipe_pkg::id_ex_t id_ex_d;
   core_pipe_pkg::id_ex_t id_ex_q;
   logic                  use_rs1;
   logic                  use_rs2;
   logic                  ex_is_load;

   assign ir  = if_id_i.instr;
   assign ins = if_id_i.instr;

   function automatic rv_isa_pkg::word_t read_reg(rv_isa_pkg::reg_idx_t idx);
      if (idx == '0)
         return '0;
      if (wb_i.we && wb_i.rd == idx)
         return wb_i.data;   // write-first
      return regs[idx];
   endfunction

   always_comb begin
      id_ex_d         = '0;
      id_ex_d.valid   = if_id_i.valid;
      id_ex_d.pc      = if_id_i.pc;
      id_ex_d.rs1_idx = ins.rs1;
      id_ex_d.rs2_idx = ins.rs2;
      id_ex_d.rd      = ins.rd;
      id_ex_d.rs1_val = read_reg(ins.rs1);
      id_ex_d.rs2_val = read_reg(ins.rs2);
      id_ex_d.alu_op  = core_pipe_pkg::ALU_ADD;
      id_ex_d.wb_sel  = core_pipe_pkg::WB_ALU;
      id_ex_d.mem_op  = core_pipe_pkg::MEM_NONE;
      imm_kind        = rv_isa_pkg::IMM_I;
      use_rs1         = 1'b1;
      use_rs2         = 1'b0;
      case (ins.opcode)
         rv_isa_pkg::OP_REG: begin
            use_rs2        = 1'b1;
            id_ex_d.reg_we = 1'b1;
            case (ins.funct3)
               rv_isa_pkg::F3_ADD: id_ex_d.alu_op = (ins.funct7 == rv_isa_pkg::F7_SUB) ?
                                                    core_pipe_pkg::ALU_SUB :
                                                    core_pipe_pkg::ALU_ADD;
               rv_isa_pkg::F3_SLT: id_ex_d.alu_op = core_pipe_pkg::ALU_SLT;
               rv_isa_pkg::F3_XOR: id_ex_d.alu_op = core_pipe_pkg::ALU_XOR;
               rv_isa_pkg::F3_OR:  id_ex_d.alu_op = core_pipe_pkg::ALU_OR;
               rv_isa_pkg::F3_AND: id_ex_d.alu_op = core_pipe_pkg::ALU_AND;
               default:            id_ex_d.reg_we = 1'b0;   // shifts, sltu
            endcase
         end
         rv_isa_pkg::OP_IMM: begin
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.reg_we  = (ins.funct3 == rv_isa_pkg::F3_ADD);   // addi only
         end
         rv_isa_pkg::OP_LUI: begin
            use_rs1         = 1'b0;
            imm_kind        = rv_isa_pkg::IMM_U;
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.alu_op  = core_pipe_pkg::ALU_PASS_B;
            id_ex_d.reg_we  = 1'b1;
         end
         rv_isa_pkg::OP_LOAD: begin
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.wb_sel  = core_pipe_pkg::WB_LOAD;
            if (ins.funct3 == rv_isa_pkg::F3_LW) begin
               id_ex_d.mem_op = core_pipe_pkg::MEM_LW;
               id_ex_d.reg_we = 1'b1;
            end else if (ins.funct3 == rv_isa_pkg::F3_LBU) begin
               id_ex_d.mem_op = core_pipe_pkg::MEM_LBU;
               id_ex_d.reg_we = 1'b1;
            end
         end
         rv_isa_pkg::OP_STORE: begin
            use_rs2         = 1'b1;
            imm_kind        = rv_isa_pkg::IMM_S;
            id_ex_d.op2_imm = 1'b1;
            if (ins.funct3 == rv_isa_pkg::F3_SW)
               id_ex_d.mem_op = core_pipe_pkg::MEM_SW;
            else if (ins.funct3 == rv_isa_pkg::F3_SB)
               id_ex_d.mem_op = core_pipe_pkg::MEM_SB;
         end
         rv_isa_pkg::OP_BRANCH: begin
            use_rs2           = 1'b1;
            imm_kind          = rv_isa_pkg::IMM_B;
            id_ex_d.op1_pc    = 1'b1;   // alu builds the target
            id_ex_d.op2_imm   = 1'b1;
            id_ex_d.is_branch = (ins.funct3 == rv_isa_pkg::F3_BEQ) ||
                                (ins.funct3 == rv_isa_pkg::F3_BNE);
            id_ex_d.branch_ne = (ins.funct3 == rv_isa_pkg::F3_BNE);
         end
         rv_isa_pkg::OP_JAL: begin
            use_rs1         = 1'b0;
            imm_kind        = rv_isa_pkg::IMM_J;
            id_ex_d.op1_pc  = 1'b1;
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.is_jal  = 1'b1;
            id_ex_d.wb_sel  = core_pipe_pkg::WB_PC4;
            id_ex_d.reg_we  = 1'b1;
         end
         default: use_rs1 = 1'b0;   // unsupported, runs as nop
      endcase
      case (imm_kind)
         rv_isa_pkg::IMM_S: id_ex_d.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         rv_isa_pkg::IMM_B: id_ex_d.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
         rv_isa_pkg::IMM_U: id_ex_d.imm = {ir[31:12], 12'b0};
         rv_isa_pkg::IMM_J: id_ex_d.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21],
                                           1'b0};
         default:           id_ex_d.imm = {{20{ir[31]}}, ir[31:20]};
      endcase
   end

   // load waiting in execute, its data shows up one stage too late
   assign ex_is_load = id_ex_q.valid && id_ex_q.reg_we && id_ex_q.rd != '0 &&
                       (id_ex_q.mem_op == core_pipe_pkg::MEM_LW ||
                        id_ex_q.mem_op == core_pipe_pkg::MEM_LBU);
   assign load_hazard_o = if_id_i.valid && ex_is_load &&
                          ((use_rs1 && ins.rs1 == id_ex_q.rd) ||
                           (use_rs2 && ins.rs2 == id_ex_q.rd));

   always_ff @(posedge clk_i) begin
      if (wb_i.we && wb_i.rd != '0)
         regs[wb_i.rd] <= wb_i.data;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         id_ex_q <= '0;
      end else if (!freeze_i) begin
         id_ex_q       <= id_ex_d;
         id_ex_q.valid <= id_ex_d.valid && !flush_i && !load_hazard_o;
      end
   end

   assign id_ex_o = id_ex_q;

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   freeze_i,
   input  core_pipe_pkg::id_ex_t  id_ex_i,
   input  core_pipe_pkg::mem_wb_t mem_wb_i,
   output logic                   redirect_valid_o,
   output rv_isa_pkg::word_t      redirect_pc_o,
   output core_pipe_pkg::ex_mem_t ex_mem_o
);

   core_pipe_pkg::ex_mem_t ex_mem_q;
   rv_isa_pkg::word_t      rs1_fwd;
   rv_isa_pkg::word_t      rs2_fwd;
   rv_isa_pkg::word_t      op_a;
   rv_isa_pkg::word_t      op_b;
   rv_isa_pkg::word_t      alu_res;
   logic                   taken;

   // newest value of a source register, EX/MEM first
   function automatic rv_isa_pkg::word_t forward(rv_isa_pkg::reg_idx_t idx,
                                                 rv_isa_pkg::word_t    reg_val);
      if (idx == '0)
         return reg_val;
      if (ex_mem_q.valid && ex_mem_q.reg_we && ex_mem_q.rd == idx)
         return ex_mem_q.alu;
      if (mem_wb_i.valid && mem_wb_i.reg_we && mem_wb_i.rd == idx) begin
         if (mem_wb_i.wb_sel == core_pipe_pkg::WB_LOAD)
            return mem_wb_i.load;
         return mem_wb_i.alu;
      end
      return reg_val;
   endfunction

   always_comb begin
      rs1_fwd = forward(id_ex_i.rs1_idx, id_ex_i.rs1_val);
      rs2_fwd = forward(id_ex_i.rs2_idx, id_ex_i.rs2_val);
      op_a    = id_ex_i.op1_pc ? id_ex_i.pc : rs1_fwd;
      op_b    = id_ex_i.op2_imm ? id_ex_i.imm : rs2_fwd;
      case (id_ex_i.alu_op)
         core_pipe_pkg::ALU_SUB:    alu_res = op_a - op_b;
         core_pipe_pkg::ALU_AND:    alu_res = op_a & op_b;
         core_pipe_pkg::ALU_OR:     alu_res = op_a | op_b;
         core_pipe_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
         core_pipe_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
         core_pipe_pkg::ALU_PASS_B: alu_res = op_b;
         default:                   alu_res = op_a + op_b;
      endcase
   end

   // beq/bne compare the forwarded registers, not the alu operands
   assign taken = id_ex_i.is_branch && ((rs1_fwd == rs2_fwd) != id_ex_i.branch_ne);

   assign redirect_valid_o = id_ex_i.valid && (taken || id_ex_i.is_jal);
   assign redirect_pc_o    = alu_res;   // pc + imm

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_mem_q <= '0;
      end else if (!freeze_i) begin
         ex_mem_q.valid      <= id_ex_i.valid;
         ex_mem_q.pc         <= id_ex_i.pc;
         ex_mem_q.alu        <= alu_res;
         ex_mem_q.store_data <= rs2_fwd;
         ex_mem_q.mem_op     <= id_ex_i.mem_op;
         ex_mem_q.wb_sel     <= id_ex_i.wb_sel;
         ex_mem_q.rd         <= id_ex_i.rd;
         ex_mem_q.reg_we     <= id_ex_i.reg_we;
      end
   end

   assign ex_mem_o = ex_mem_q;

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   freeze_i,
   input  core_pipe_pkg::ex_mem_t ex_mem_i,
   input  rv_isa_pkg::word_t      cache_data_i,
   output rv_isa_pkg::waddr_t     cache_address_o,
   output rv_isa_pkg::strobe_t    cache_write_en_o,
   output rv_isa_pkg::word_t      cache_data_o,
   output core_pipe_pkg::mem_wb_t mem_wb_o,
   output core_pipe_pkg::wb_t     wb_o
);

   core_pipe_pkg::mem_wb_t mem_wb_q;
   rv_isa_pkg::word_t      load_val;
   logic [7:0]             load_byte;
   logic                   is_sw;
   logic                   is_sb;

   assign cache_address_o = ex_mem_i.alu[31:2];
   assign is_sw = ex_mem_i.valid && ex_mem_i.mem_op == core_pipe_pkg::MEM_SW;
   assign is_sb = ex_mem_i.valid && ex_mem_i.mem_op == core_pipe_pkg::MEM_SB;
   assign cache_data_o = is_sb ? {4{ex_mem_i.store_data[7:0]}} : ex_mem_i.store_data;

   always_comb begin
      cache_write_en_o = '0;
      if (!freeze_i) begin   // store goes out once, in the cycle it completes
         if (is_sw)
            cache_write_en_o = 4'b1111;
         else if (is_sb)
            cache_write_en_o = 4'b0001 << ex_mem_i.alu[1:0];
      end
   end

   assign load_byte = cache_data_i[{ex_mem_i.alu[1:0], 3'b000} +: 8];
   assign load_val  = (ex_mem_i.mem_op == core_pipe_pkg::MEM_LBU) ? {24'b0, load_byte} :
                                                                     cache_data_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mem_wb_q <= '0;
      end else if (!freeze_i) begin
         mem_wb_q.valid  <= ex_mem_i.valid;
         mem_wb_q.pc     <= ex_mem_i.pc;
         mem_wb_q.alu    <= ex_mem_i.alu;
         mem_wb_q.load   <= load_val;
         mem_wb_q.wb_sel <= ex_mem_i.wb_sel;
         mem_wb_q.rd     <= ex_mem_i.rd;
         mem_wb_q.reg_we <= ex_mem_i.reg_we;
      end
   end

   // writeback value
   always_comb begin
      wb_o.we = mem_wb_q.valid && mem_wb_q.reg_we;
      wb_o.rd = mem_wb_q.rd;
      case (mem_wb_q.wb_sel)
         core_pipe_pkg::WB_LOAD: wb_o.data = mem_wb_q.load;
         core_pipe_pkg::WB_PC4:  wb_o.data = mem_wb_q.pc + 32'd4;   // jal link
         default:                wb_o.data = mem_wb_q.alu;
      endcase
   end

   assign mem_wb_o = mem_wb_q;

endmodule

//--- rtl/core.sv
`timescale 1ns/1ps

module core #(
   parameter rv_isa_pkg::word_t RESET_PC = '0
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  logic                instr_cache_blocking_n_i,
   input  rv_isa_pkg::word_t   instr_cache_data_i,
   output rv_isa_pkg::waddr_t  instr_cache_address_o,

   input  logic                data_cache_blocking_n_i,
   input  rv_isa_pkg::word_t   data_cache_data_i,
   output rv_isa_pkg::waddr_t  data_cache_address_o,
   output rv_isa_pkg::strobe_t data_cache_write_en_o,
   output rv_isa_pkg::word_t   data_cache_data_o
);

   core_pipe_pkg::if_id_t  if_id;
   core_pipe_pkg::id_ex_t  id_ex;
   core_pipe_pkg::ex_mem_t ex_mem;
   core_pipe_pkg::mem_wb_t mem_wb;
   core_pipe_pkg::wb_t     wb;
   logic                   load_hazard;
   logic                   redirect_valid;
   rv_isa_pkg::word_t      redirect_pc;
   logic                   freeze;

   assign freeze = ~data_cache_blocking_n_i;   // dcache busy holds the whole pipe

   fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
      .clk_i              (clk_i),
      .rst_n_i            (rst_n_i),
      .freeze_i           (freeze),
      .stall_i            (load_hazard),
      .redirect_valid_i   (redirect_valid),
      .redirect_pc_i      (redirect_pc),
      .cache_blocking_n_i (instr_cache_blocking_n_i),
      .cache_data_i       (instr_cache_data_i),
      .cache_address_o    (instr_cache_address_o),
      .if_id_o            (if_id)
   );

   decode_stage u_decode (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .freeze_i      (freeze),
      .flush_i       (redirect_valid),
      .if_id_i       (if_id),
      .wb_i          (wb),
      .load_hazard_o (load_hazard),
      .id_ex_o       (id_ex)
   );

   execute_stage u_execute (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .freeze_i         (freeze),
      .id_ex_i          (id_ex),
      .mem_wb_i         (mem_wb),
      .redirect_valid_o (redirect_valid),
      .redirect_pc_o    (redirect_pc),
      .ex_mem_o         (ex_mem)
   );

   memory_stage u_memory (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .freeze_i         (freeze),
      .ex_mem_i         (ex_mem),
      .cache_data_i     (data_cache_data_i),
      .cache_address_o  (data_cache_address_o),
      .cache_write_en_o (data_cache_write_en_o),
      .cache_data_o     (data_cache_data_o),
      .mem_wb_o         (mem_wb),
      .wb_o             (wb)
   );

endmodule

//--- verif/core_tb.sv
`timescale 1ns/1ps

module core_tb;

   localparam int TIMEOUT_CYCLES = 2000;
   localparam int QUIET_CYCLES   = 40;   // window for stray stores after the last one

   logic                clk = 1'b0;
   logic                rst_n;
   logic                icache_blk_n;
   logic                dcache_blk_n;
   rv_isa_pkg::word_t   icache_data;
   rv_isa_pkg::waddr_t  icache_addr;
   rv_isa_pkg::word_t   dcache_rdata;
   rv_isa_pkg::waddr_t  dcache_addr;
   rv_isa_pkg::strobe_t dcache_we;
   rv_isa_pkg::word_t   dcache_wdata;

   rv_isa_pkg::word_t   imem [0:63];
   rv_isa_pkg::word_t   dmem [0:63];
   rv_isa_pkg::waddr_t  exp_addr [$];
   rv_isa_pkg::strobe_t exp_strobe [$];
   rv_isa_pkg::word_t   exp_data [$];
   int                  exp_count;
   int                  got_count;
   int                  value_errs;
   int                  other_errs;
   integer              seed = 32'ha732;

   core #(.RESET_PC(32'h0)) UUT (
      .clk_i                    (clk),
      .rst_n_i                  (rst_n),
      .instr_cache_blocking_n_i (icache_blk_n),
      .instr_cache_data_i       (icache_data),
      .instr_cache_address_o    (icache_addr),
      .data_cache_blocking_n_i  (dcache_blk_n),
      .data_cache_data_i        (dcache_rdata),
      .data_cache_address_o     (dcache_addr),
      .data_cache_write_en_o    (dcache_we),
      .data_cache_data_o        (dcache_wdata)
   );

   initial begin
      forever #20 clk = ~clk;
   end

   // caches answer in the same cycle
   assign icache_data  = icache_blk_n ? imem[icache_addr[7:2]] : 32'hdead_beef;
   assign dcache_rdata = dcache_blk_n ? dmem[dcache_addr[7:2]] : 32'hdead_beef;

   function automatic rv_isa_pkg::word_t fill_word(int idx);
      return rv_isa_pkg::word_t'(idx + 1) * 32'h9e37_79b9;
   endfunction

   function automatic rv_isa_pkg::word_t byte_mask(rv_isa_pkg::strobe_t strb);
      return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
   endfunction

   function automatic rv_isa_pkg::word_t r_type(logic [6:0] f7, int rs2, int rs1,
                                                logic [2:0] f3, int rd);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_isa_pkg::OP_REG};
   endfunction

   function automatic rv_isa_pkg::word_t i_type(logic [6:0] op, int imm, int rs1,
                                                logic [2:0] f3, int rd);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
   endfunction

   function automatic rv_isa_pkg::word_t s_type(int imm, int rs2, int rs1, logic [2:0] f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], rv_isa_pkg::OP_STORE};
   endfunction

   function automatic rv_isa_pkg::word_t b_type(int imm, int rs2, int rs1, logic [2:0] f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
              rv_isa_pkg::OP_BRANCH};
   endfunction

   function automatic rv_isa_pkg::word_t u_type(int imm, int rd);
      return {imm[19:0], rd[4:0], rv_isa_pkg::OP_LUI};
   endfunction

   function automatic rv_isa_pkg::word_t j_type(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_isa_pkg::OP_JAL};
   endfunction

   task automatic load_program();
      for (int i = 0; i < 64; i++) begin
         imem[i] = 32'h0000_0013;   // addi x0, x0, 0
         dmem[i] = fill_word(i);
      end
      imem[0]  = u_type(20'h12345, 1);
      imem[1]  = i_type(rv_isa_pkg::OP_IMM, 12'h067, 0, 3'b000, 2);
      imem[2]  = r_type(7'h00, 2, 1, 3'b000, 3);   // add with both sources forwarded
      imem[3]  = i_type(rv_isa_pkg::OP_IMM, 12'h080, 0, 3'b000, 10);
      imem[4]  = s_type(0, 3, 10, 3'b010);
      imem[5]  = r_type(7'h20, 3, 2, 3'b000, 4);   // sub goes negative
      imem[6]  = s_type(4, 4, 10, 3'b010);
      imem[7]  = r_type(7'h00, 2, 4, 3'b010, 5);   // slt
      imem[8]  = r_type(7'h00, 4, 2, 3'b010, 6);
      imem[9]  = r_type(7'h00, 4, 3, 3'b100, 7);   // xor
      imem[10] = r_type(7'h00, 7, 5, 3'b110, 8);   // or
      imem[11] = r_type(7'h00, 3, 8, 3'b111, 9);   // and
      imem[12] = s_type(8, 5, 10, 3'b010);
      imem[13] = s_type(12, 6, 10, 3'b010);
      imem[14] = s_type(16, 9, 10, 3'b010);
      imem[15] = i_type(rv_isa_pkg::OP_LOAD, 12'h040, 0, 3'b010, 11);
      imem[16] = i_type(rv_isa_pkg::OP_IMM, 1, 11, 3'b000, 12);   // load-use
      imem[17] = s_type(20, 12, 10, 3'b010);
      imem[18] = s_type(33, 3, 10, 3'b000);   // sb to lane 1
      imem[19] = i_type(rv_isa_pkg::OP_LOAD, 33, 10, 3'b100, 13);
      imem[20] = r_type(7'h00, 13, 13, 3'b000, 14);
      imem[21] = s_type(24, 14, 10, 3'b010);
      imem[22] = i_type(rv_isa_pkg::OP_LOAD, 12'h043, 0, 3'b100, 15);   // top byte
      imem[23] = s_type(28, 15, 10, 3'b010);
      imem[24] = b_type(8, 6, 5, 3'b000);    // beq not taken
      imem[25] = b_type(8, 6, 5, 3'b001);    // bne taken
      imem[26] = s_type(36, 3, 10, 3'b010);  // skipped
      imem[27] = j_type(8, 16);
      imem[28] = s_type(40, 3, 10, 3'b010);  // skipped
      imem[29] = s_type(44, 16, 10, 3'b010); // link value
      imem[30] = b_type(8, 2, 2, 3'b000);    // beq taken
      imem[31] = s_type(48, 1, 10, 3'b010);  // skipped
      imem[32] = s_type(50, 2, 10, 3'b000);  // sb to lane 2
      imem[33] = s_type(52, 1, 10, 3'b010);
      imem[34] = j_type(0, 0);               // park here
   endtask

   // ISA level run of imem that fills the expected store queues
   function automatic int rv_model();
      rv_isa_pkg::word_t   x [0:31];
      rv_isa_pkg::word_t   mem [0:63];
      rv_isa_pkg::word_t   pc;
      rv_isa_pkg::word_t   ins;
      rv_isa_pkg::word_t   imm_i;
      rv_isa_pkg::word_t   imm_s;
      rv_isa_pkg::word_t   imm_b;
      rv_isa_pkg::word_t   imm_j;
      rv_isa_pkg::word_t   a;
      rv_isa_pkg::word_t   data;
      rv_isa_pkg::word_t   next_pc;
      rv_isa_pkg::strobe_t strb;
      logic [4:0]          rd;
      logic [4:0]          rs1;
      logic [4:0]          rs2;
      logic [2:0]          f3;
      pc = '0;
      for (int i = 0; i < 32; i++)
         x[i] = '0;
      for (int i = 0; i < 64; i++)
         mem[i] = fill_word(i);
      for (int step = 0; step < 500; step++) begin
         ins   = imem[pc[7:2]];
         rd    = ins[11:7];
         rs1   = ins[19:15];
         rs2   = ins[24:20];
         f3    = ins[14:12];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         next_pc = pc + 32'd4;
         case (ins[6:0])
            rv_isa_pkg::OP_REG: begin
               case (f3)
                  3'b000: x[rd] = (ins[31:25] == 7'b0100000) ? x[rs1] - x[rs2] :
                                                               x[rs1] + x[rs2];
                  3'b010: x[rd] = ($signed(x[rs1]) < $signed(x[rs2])) ? 32'd1 : 32'd0;
                  3'b100: x[rd] = x[rs1] ^ x[rs2];
                  3'b110: x[rd] = x[rs1] | x[rs2];
                  3'b111: x[rd] = x[rs1] & x[rs2];
                  default: ;
               endcase
            end
            rv_isa_pkg::OP_IMM: if (f3 == 3'b000) x[rd] = x[rs1] + imm_i;
            rv_isa_pkg::OP_LUI: x[rd] = {ins[31:12], 12'h000};
            rv_isa_pkg::OP_LOAD: begin
               a = x[rs1] + imm_i;
               if (f3 == 3'b010)
                  x[rd] = mem[a[7:2]];
               else if (f3 == 3'b100)
                  x[rd] = (mem[a[7:2]] >> {a[1:0], 3'b000}) & 32'h0000_00ff;
            end
            rv_isa_pkg::OP_STORE: begin
               a    = x[rs1] + imm_s;
               strb = (f3 == 3'b010) ? 4'b1111 : 4'b0001 << a[1:0];
               data = (f3 == 3'b010) ? x[rs2] : {4{x[rs2][7:0]}};
               mem[a[7:2]] = (mem[a[7:2]] & ~byte_mask(strb)) | (data & byte_mask(strb));
               exp_addr.push_back(a[31:2]);
               exp_strobe.push_back(strb);
               exp_data.push_back(data);
            end
            rv_isa_pkg::OP_BRANCH: begin
               if ((f3 == 3'b000 && x[rs1] == x[rs2]) || (f3 == 3'b001 && x[rs1] != x[rs2]))
                  next_pc = pc + imm_b;
            end
            rv_isa_pkg::OP_JAL: begin
               if (imm_j == '0)
                  return exp_addr.size();   // jump to self ends the program
               x[rd]   = pc + 32'd4;
               next_pc = pc + imm_j;
            end
            default: ;
         endcase
         x[0] = '0;
         pc   = next_pc;
      end
      $display("reference model never reached the final jump");
      return -1;
   endfunction

   task automatic check_addr(input string name, input rv_isa_pkg::waddr_t got,
                             input rv_isa_pkg::waddr_t exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_strobe(input string name, input rv_isa_pkg::strobe_t got,
                               input rv_isa_pkg::strobe_t exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                             input rv_isa_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   // random blocking on both caches
   always @(negedge clk) begin
      icache_blk_n = ($random(seed) & 3) != 0;
      dcache_blk_n = ($random(seed) & 3) != 0;
   end

   // dcache write port
   always @(posedge clk) begin
      if (dcache_blk_n && dcache_we != '0)
         dmem[dcache_addr[7:2]] = (dmem[dcache_addr[7:2]] & ~byte_mask(dcache_we)) |
                                  (dcache_wdata & byte_mask(dcache_we));
   end

   // each completed store against the next expected one
   always @(posedge clk) begin
      if (rst_n && dcache_we != '0) begin
         if (got_count >= exp_count) begin
            $display("unexpected extra store at %0t to byte address %h",
                     $time, {dcache_addr, 2'b00});
            other_errs++;
         end else begin
            check_addr("data_cache_address_o", dcache_addr, exp_addr[got_count]);
            check_strobe("data_cache_write_en_o", dcache_we, exp_strobe[got_count]);
            check_word("data_cache_data_o", dcache_wdata, exp_data[got_count]);
         end
         got_count++;
      end
   end

   initial begin
      int cycles;
      rst_n        = 1'b0;
      icache_blk_n = 1'b1;
      dcache_blk_n = 1'b1;
      value_errs   = 0;
      other_errs   = 0;
      got_count    = 0;
      load_program();
      exp_count = rv_model();
      if (exp_count < 0)
         other_errs++;
      repeat (10) begin
         @(negedge clk);
         check_strobe("data_cache_write_en_o", dcache_we, 4'b0000);
      end
      rst_n  = 1'b1;
      cycles = 0;
      while (got_count < exp_count && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (got_count < exp_count) begin
         $display("timed out with %0d of %0d stores received", got_count, exp_count);
         other_errs++;
      end
      cycles = 0;
      while (cycles < QUIET_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (got_count != exp_count) begin
         $display("store count is %0d, the program makes %0d", got_count, exp_count);
         other_errs++;
      end
      $display("value errors %0d, other errors %0d, stores %0d of %0d",
               value_errs, other_errs, got_count, exp_count);
      if (value_errs == 0 && other_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- core.f
rtl/rv_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core.sv
verif/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it and search the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal --top-module core_tb -f core.f \
   -Mdir "$BUILD" -o core_tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD/core_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
